// ==== src/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_BITS    = 32;
    localparam int OFFSET_BITS  = 3;
    localparam int INDEX_BITS   = 4;
    localparam int CACHE_LINES  = 16;
    localparam int TAG_BITS     = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int MSHR_ENTRIES = 4;
    localparam int QUEUE_DEPTH  = 2;
    // tag 0 is reserved for "no transaction"
    localparam int MEM_TAG_BITS = 4;
    localparam int LQ_IDX_BITS  = 3;

    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [31:0]             word_t;
    // eight bytes, four halves or two words
    typedef logic [63:0]             block_t;
    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [INDEX_BITS-1:0]   index_t;
    typedef logic [OFFSET_BITS-1:0]  offset_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [LQ_IDX_BITS-1:0]  lq_idx_t;
    typedef logic [MSHR_ENTRIES-1:0] entry_sel_t;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_func_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_command_e;
    typedef enum logic [1:0] {MSHR_INVALID, MSHR_PENDING, MSHR_WAIT_DATA} mshr_state_e;
    typedef enum logic {INST_LOAD, INST_STORE} inst_kind_e;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        lq_idx_t lq_idx;
    } load_req_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_func_e func;
        word_t     data;
    } store_req_t;

    typedef struct packed {
        inst_kind_e kind;
        mem_func_e  func;
        word_t      data;
        offset_t    offset;
        lq_idx_t    lq_idx;
    } queue_packet_t;

    typedef struct packed {
        logic    valid;
        lq_idx_t lq_idx;
        word_t   data;
    } load_result_t;

    typedef struct packed {
        logic                                valid;
        tag_t                                tag;
        index_t                              index;
        queue_packet_t [QUEUE_DEPTH-1:0]     packets;
        logic          [QUEUE_DEPTH-1:0]     packet_valid;
    } fill_t;

    typedef struct packed {
        mem_command_e command;
        addr_t        addr;
        block_t       data;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } miss_read_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
        block_t data;
    } victim_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== src/miss_queue.sv ====
`default_nettype none

module miss_queue
    import dcache_pkg::*;
#(
    parameter int depth = QUEUE_DEPTH
) (
    input  logic                       clock,
    input  logic                       reset,
    // slot 0 is the load lane, slot 1 the store lane
    input  queue_packet_t [1:0]        push,
    input  logic          [1:0]        push_valid,
    output logic          [1:0]        push_accept,
    input  logic                       flush,
    output queue_packet_t [depth-1:0]  flush_packets,
    output logic          [depth-1:0]  flush_valid
);

    queue_packet_t [depth-1:0]  slots, slots_next;
    logic [$clog2(depth+1)-1:0] count, count_next;
    logic [$clog2(depth+1)-1:0] tail, tail_next;

    always_comb begin
        slots_next    = slots;
        count_next    = count;
        tail_next     = tail;
        push_accept   = '0;
        flush_packets = '0;
        flush_valid   = '0;

        if (flush) begin
            // oldest first, then empty
            for (int i = 0; i < depth; i++) begin
                if (i < count) begin
                    flush_valid[i]   = 1'b1;
                    flush_packets[i] = slots[i];
                end
            end
            count_next = '0;
            tail_next  = '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (push_valid[i] && count_next < depth) begin
                    slots_next[tail_next] = push[i];
                    tail_next             = (tail_next == depth - 1) ? '0 : tail_next + 1'b1;
                    count_next            = count_next + 1'b1;
                    push_accept[i]        = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            tail  <= '0;
        end else begin
            count <= count_next;
            tail  <= tail_next;
        end
    end

    always_ff @(posedge clock) begin
        slots <= slots_next;
    end

    count_in_range: assert property (@(posedge clock) disable iff (reset) count <= depth);

endmodule

`default_nettype wire

// ==== src/miss_tracker.sv ====
`default_nettype none

module miss_tracker
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  load_req_t  load_req,
    input  store_req_t store_req,
    input  logic       load_miss,
    input  logic       store_miss,
    output logic       load_queued,
    output logic       store_queued,
    output miss_read_t miss_read,
    input  logic       issue_blocked,
    input  mem_tag_t   mem_response_tag,
    input  mem_tag_t   mem_data_tag,
    output fill_t      fill
);

    typedef struct packed {
        mshr_state_e state;
        tag_t        tag;
        index_t      index;
        mem_tag_t    mem_tag;
    } entry_t;

    entry_t [MSHR_ENTRIES-1:0] entries, entries_next;

    queue_packet_t [MSHR_ENTRIES-1:0][1:0]             push;
    logic          [MSHR_ENTRIES-1:0][1:0]             push_valid;
    logic          [MSHR_ENTRIES-1:0][1:0]             push_accept;
    queue_packet_t [MSHR_ENTRIES-1:0][QUEUE_DEPTH-1:0] flush_packets;
    logic          [MSHR_ENTRIES-1:0][QUEUE_DEPTH-1:0] flush_valid;

    // lane 0 is the load port, lane 1 the store port
    logic          [1:0] lane_miss;
    addr_t         [1:0] lane_addr;
    queue_packet_t [1:0] lane_packet;
    entry_sel_t    [1:0] lane_sel;

    entry_sel_t pending, issue_sel, fill_sel;

    function automatic entry_sel_t match_block(entry_t [MSHR_ENTRIES-1:0] table_in, addr_t addr);
        entry_sel_t sel;
        for (int j = 0; j < MSHR_ENTRIES; j++) begin
            sel[j] = table_in[j].state != MSHR_INVALID
                  && table_in[j].tag == addr_tag(addr)
                  && table_in[j].index == addr_index(addr);
        end
        return sel;
    endfunction

    function automatic entry_sel_t lowest_free(entry_t [MSHR_ENTRIES-1:0] table_in);
        entry_sel_t free;
        for (int j = 0; j < MSHR_ENTRIES; j++) begin
            free[j] = table_in[j].state == MSHR_INVALID;
        end
        return free & (~free + 1'b1);
    endfunction

    assign lane_miss   = {store_req.valid && store_miss, load_req.valid && load_miss};
    assign lane_addr   = {store_req.addr, load_req.addr};
    assign lane_packet = {
        queue_packet_t'{INST_STORE, store_req.func, store_req.data,
                        addr_offset(store_req.addr), '0},
        queue_packet_t'{INST_LOAD, MEM_WORD, '0, addr_offset(load_req.addr), load_req.lq_idx}
    };

    for (genvar j = 0; j < MSHR_ENTRIES; j++) begin : g_entry
        assign pending[j]  = entries[j].state == MSHR_PENDING;
        assign fill_sel[j] = entries[j].state == MSHR_WAIT_DATA && mem_data_tag != '0
                          && entries[j].mem_tag == mem_data_tag;

        miss_queue u_queue (
            .clock         (clock),
            .reset         (reset),
            .push          (push[j]),
            .push_valid    (push_valid[j]),
            .push_accept   (push_accept[j]),
            .flush         (fill_sel[j]),
            .flush_packets (flush_packets[j]),
            .flush_valid   (flush_valid[j])
        );
    end

    // lowest pending entry owns the read slot
    assign issue_sel = pending & (~pending + 1'b1);

    always_comb begin
        entries_next = entries;
        push         = '0;
        push_valid   = '0;
        lane_sel     = '0;

        // merge or allocate; store lane sees the load's allocation
        for (int lane = 0; lane < 2; lane++) begin
            if (lane_miss[lane]) begin
                lane_sel[lane] = match_block(entries_next, lane_addr[lane]);
                if (lane_sel[lane] == '0) begin
                    lane_sel[lane] = lowest_free(entries_next);
                end
            end
            for (int j = 0; j < MSHR_ENTRIES; j++) begin
                if (lane_sel[lane][j]) begin
                    push[j][lane]       = lane_packet[lane];
                    push_valid[j][lane] = 1'b1;
                    if (entries_next[j].state == MSHR_INVALID) begin
                        entries_next[j].state = MSHR_PENDING;
                        entries_next[j].tag   = addr_tag(lane_addr[lane]);
                        entries_next[j].index = addr_index(lane_addr[lane]);
                    end
                end
            end
        end

        for (int j = 0; j < MSHR_ENTRIES; j++) begin
            if (issue_sel[j] && !issue_blocked && mem_response_tag != '0) begin
                entries_next[j].state   = MSHR_WAIT_DATA;
                entries_next[j].mem_tag = mem_response_tag;
            end
            if (fill_sel[j]) begin
                entries_next[j].state = MSHR_INVALID;
            end
        end
    end

    always_comb begin
        load_queued  = 1'b0;
        store_queued = 1'b0;
        miss_read    = '0;
        fill         = '0;
        for (int j = 0; j < MSHR_ENTRIES; j++) begin
            load_queued  = load_queued | (lane_sel[0][j] & push_accept[j][0]);
            store_queued = store_queued | (lane_sel[1][j] & push_accept[j][1]);
            if (issue_sel[j]) begin
                miss_read.valid = 1'b1;
                miss_read.addr  = {entries[j].tag, entries[j].index, {OFFSET_BITS{1'b0}}};
            end
            if (fill_sel[j]) begin
                fill.valid        = 1'b1;
                fill.tag          = entries[j].tag;
                fill.index        = entries[j].index;
                fill.packets      = flush_packets[j];
                fill.packet_valid = flush_valid[j];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < MSHR_ENTRIES; j++) begin
                entries[j].state <= MSHR_INVALID;
            end
        end else begin
            entries <= entries_next;
        end
    end

    // a block is tracked by one entry at most
    for (genvar a = 0; a < MSHR_ENTRIES; a++) begin : g_unique
        for (genvar b = a + 1; b < MSHR_ENTRIES; b++) begin : g_pair
            unique_block: assert property (@(posedge clock) disable iff (reset)
                !(entries[a].state != MSHR_INVALID && entries[b].state != MSHR_INVALID
                  && entries[a].tag == entries[b].tag && entries[a].index == entries[b].index));
        end
    end

    single_fill_match: assert property (@(posedge clock) disable iff (reset) $onehot0(fill_sel));

endmodule

`default_nettype wire

// ==== src/cache_array.sv ====
`default_nettype none

module cache_array
    import dcache_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  load_req_t                      load_req,
    input  store_req_t                     store_req,
    input  fill_t                          fill,
    input  block_t                         mem_data,
    output load_result_t                   load_hit_result,
    output logic                           load_miss,
    output logic                           store_miss,
    output load_result_t [QUEUE_DEPTH-1:0] fill_results,
    output victim_t                        victim
);

    typedef struct packed {
        logic   valid;
        logic   dirty;
        tag_t   tag;
        block_t data;
    } line_t;

    line_t [CACHE_LINES-1:0] lines, lines_next;

    index_t load_index, store_index;
    logic   store_hit;

    assign load_index  = addr_index(load_req.addr);
    assign store_index = addr_index(store_req.addr);

    function automatic block_t merge_store(block_t block, mem_func_e func, offset_t offset,
                                           word_t data);
        block_t merged;
        merged = block;
        case (func)
            MEM_BYTE: merged[8 * offset +: 8]        = data[7:0];
            MEM_HALF: merged[16 * offset[2:1] +: 16] = data[15:0];
            default:  merged[32 * offset[2] +: 32]   = data;
        endcase
        return merged;
    endfunction

    function automatic word_t read_word(block_t block, offset_t offset);
        return block[32 * offset[2] +: 32];
    endfunction

    always_comb begin
        lines_next   = lines;
        victim       = '0;
        fill_results = '0;

        if (fill.valid) begin
            // dirty line leaves for the writeback buffer
            if (lines[fill.index].valid && lines[fill.index].dirty) begin
                victim.valid = 1'b1;
                victim.addr  = {lines[fill.index].tag, fill.index, {OFFSET_BITS{1'b0}}};
                victim.data  = lines[fill.index].data;
            end
            lines_next[fill.index] = '{valid: 1'b1, dirty: 1'b0, tag: fill.tag, data: mem_data};

            // queued requests in arrival order
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (fill.packet_valid[i]) begin
                    if (fill.packets[i].kind == INST_STORE) begin
                        lines_next[fill.index].dirty = 1'b1;
                        lines_next[fill.index].data  = merge_store(lines_next[fill.index].data,
                            fill.packets[i].func, fill.packets[i].offset, fill.packets[i].data);
                    end else begin
                        fill_results[i].valid  = 1'b1;
                        fill_results[i].lq_idx = fill.packets[i].lq_idx;
                        fill_results[i].data   = read_word(lines_next[fill.index].data,
                                                           fill.packets[i].offset);
                    end
                end
            end
        end

        // hits look at the post-fill contents
        load_hit_result = '0;
        load_miss       = 1'b0;
        if (load_req.valid) begin
            if (lines_next[load_index].valid
                    && lines_next[load_index].tag == addr_tag(load_req.addr)) begin
                load_hit_result.valid  = 1'b1;
                load_hit_result.lq_idx = load_req.lq_idx;
                load_hit_result.data   = read_word(lines_next[load_index].data,
                                                   addr_offset(load_req.addr));
            end else begin
                load_miss = 1'b1;
            end
        end

        store_hit  = lines_next[store_index].valid
                  && lines_next[store_index].tag == addr_tag(store_req.addr);
        store_miss = store_req.valid && !store_hit;
        if (store_req.valid && store_hit) begin
            lines_next[store_index].dirty = 1'b1;
            lines_next[store_index].data  = merge_store(lines_next[store_index].data,
                store_req.func, addr_offset(store_req.addr), store_req.data);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < CACHE_LINES; k++) begin
                lines[k].valid <= 1'b0;
                lines[k].dirty <= 1'b0;
            end
        end else begin
            lines <= lines_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/memory_port.sv ====
`default_nettype none

module memory_port
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  victim_t    victim,
    input  miss_read_t miss_read,
    output mem_req_t   mem_req,
    output logic       issue_blocked
);

    // one-entry writeback buffer
    logic   wb_valid;
    addr_t  wb_addr;
    block_t wb_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= victim.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (victim.valid) begin
            wb_addr <= victim.addr;
            wb_data <= victim.data;
        end
    end

    // writeback goes ahead of any read
    assign issue_blocked = wb_valid;

    always_comb begin
        mem_req = '{command: MEM_NONE, addr: '0, data: '0};
        if (wb_valid) begin
            mem_req = '{command: MEM_STORE, addr: wb_addr, data: wb_data};
        end else if (miss_read.valid) begin
            mem_req = '{command: MEM_LOAD, addr: miss_read.addr, data: '0};
        end
    end

    // no new victim while the buffer still holds one
    no_victim_overrun: assert property (@(posedge clock) disable iff (reset)
        victim.valid |-> !wb_valid);

endmodule

`default_nettype wire

// ==== src/data_cache.sv ====
`default_nettype none

module data_cache
    import dcache_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  load_req_t                      load_req,
    input  store_req_t                     store_req,
    output logic                           load_accept,
    output logic                           store_accept,
    output load_result_t                   load_hit_result,
    output load_result_t [QUEUE_DEPTH-1:0] fill_results,
    output mem_req_t                       mem_req,
    input  mem_tag_t                       mem_response_tag,
    input  block_t                         mem_data,
    input  mem_tag_t                       mem_data_tag
);

    logic       load_miss, store_miss;
    logic       load_queued, store_queued;
    logic       issue_blocked;
    miss_read_t miss_read;
    fill_t      fill;
    victim_t    victim;

    // hit, or miss taken by an entry queue
    assign load_accept  = (load_req.valid && !load_miss) || load_queued;
    assign store_accept = (store_req.valid && !store_miss) || store_queued;

    miss_tracker u_tracker (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .store_req        (store_req),
        .load_miss        (load_miss),
        .store_miss       (store_miss),
        .load_queued      (load_queued),
        .store_queued     (store_queued),
        .miss_read        (miss_read),
        .issue_blocked    (issue_blocked),
        .mem_response_tag (mem_response_tag),
        .mem_data_tag     (mem_data_tag),
        .fill             (fill)
    );

    cache_array u_array (
        .clock           (clock),
        .reset           (reset),
        .load_req        (load_req),
        .store_req       (store_req),
        .fill            (fill),
        .mem_data        (mem_data),
        .load_hit_result (load_hit_result),
        .load_miss       (load_miss),
        .store_miss      (store_miss),
        .fill_results    (fill_results),
        .victim          (victim)
    );

    memory_port u_mem_port (
        .clock         (clock),
        .reset         (reset),
        .victim        (victim),
        .miss_read     (miss_read),
        .mem_req       (mem_req),
        .issue_blocked (issue_blocked)
    );

endmodule

`default_nettype wire

// ==== testbench/memory_model.sv ====
`default_nettype none

module memory_model
    import dcache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  mem_req_t mem_req,
    output mem_tag_t mem_response_tag,
    output block_t   mem_data,
    output mem_tag_t mem_data_tag
);

    // word-addressed backing store, untouched words follow a fixed pattern
    word_t    contents [addr_t];
    logic     pend_valid [16];
    addr_t    pend_addr [16];
    int       pend_due [16];
    mem_tag_t next_tag;
    int       cycle;
    int       seed = 32'h8f39_b8b2;

    function automatic word_t initial_word(addr_t word_addr);
        return word_addr * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    function automatic word_t read_word(addr_t word_addr);
        return contents.exists(word_addr) ? contents[word_addr] : initial_word(word_addr);
    endfunction

    // reads are taken in the same cycle unless stalled
    assign mem_response_tag = (mem_req.command == MEM_LOAD && !stall) ? next_tag : '0;

    always @(posedge clock) begin
        logic  sent;
        addr_t word_addr;
        if (reset) begin
            next_tag     <= 4'd1;
            cycle        <= 0;
            mem_data_tag <= '0;
            mem_data     <= '0;
            for (int t = 0; t < 16; t++) begin
                pend_valid[t] = 1'b0;
            end
        end else begin
            cycle <= cycle + 1;
            if (mem_response_tag != '0) begin
                pend_valid[mem_response_tag] = 1'b1;
                pend_addr[mem_response_tag]  = mem_req.addr;
                pend_due[mem_response_tag]   = cycle + 5 + ($unsigned($random(seed)) % 4);
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            if (mem_req.command == MEM_STORE) begin
                contents[mem_req.addr >> 2]          = mem_req.data[31:0];
                contents[(mem_req.addr >> 2) + 1'b1] = mem_req.data[63:32];
            end
            // one return per cycle
            sent = 1'b0;
            mem_data_tag <= '0;
            for (int t = 1; t < 16; t++) begin
                if (!sent && pend_valid[t] && pend_due[t] <= cycle) begin
                    sent          = 1'b1;
                    pend_valid[t] = 1'b0;
                    word_addr     = pend_addr[t] >> 2;
                    mem_data_tag <= mem_tag_t'(t);
                    mem_data     <= {read_word(word_addr + 1'b1), read_word(word_addr)};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/data_cache_tb.sv ====
`default_nettype none

module data_cache_tb
    import dcache_pkg::*;
();

    logic                           clock;
    logic                           reset;
    logic                           stall;
    load_req_t                      load_req;
    store_req_t                     store_req;
    logic                           load_accept, store_accept;
    load_result_t                   load_hit_result;
    load_result_t [QUEUE_DEPTH-1:0] fill_results;
    mem_req_t                       mem_req;
    mem_tag_t                       mem_response_tag, mem_data_tag;
    block_t                         mem_data;

    word_t  shadow [addr_t];
    logic   exp_pending [8];
    word_t  exp_data [8];
    int     fill_cycle [8];
    int     cycle_count, read_count, wb_count;
    addr_t  watch_addr, wb_addr;
    block_t wb_data;
    string  test_name;
    int     seed = 32'h8f39_b8b2;

    data_cache dut0 (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .store_req        (store_req),
        .load_accept      (load_accept),
        .store_accept     (store_accept),
        .load_hit_result  (load_hit_result),
        .fill_results     (fill_results),
        .mem_req          (mem_req),
        .mem_response_tag (mem_response_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag)
    );

    memory_model memory0 (
        .clock            (clock),
        .reset            (reset),
        .stall            (stall),
        .mem_req          (mem_req),
        .mem_response_tag (mem_response_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic word_t shadow_word(addr_t word_addr);
        return shadow.exists(word_addr) ? shadow[word_addr]
                                        : word_addr * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += exp_pending[i];
        end
        return n;
    endfunction

    // called at a falling edge, returns at a falling edge
    task automatic issue_load(input addr_t addr, input lq_idx_t lq, output logic hit);
        int waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        load_req = '{valid: 1'b1, addr: addr, lq_idx: lq};
        while (!accepted) begin
            #5;
            if (load_accept) begin
                accepted = 1'b1;
                hit      = load_hit_result.valid;
                if (hit) begin
                    check_value(test_name, shadow_word(addr >> 2), load_hit_result.data);
                end else begin
                    exp_pending[lq] = 1'b1;
                    exp_data[lq]    = shadow_word(addr >> 2);
                end
            end else if (waited >= 60) begin
                report_failure("a load request was never accepted");
            end
            waited++;
            @(negedge clock);
        end
        load_req.valid = 1'b0;
    endtask

    task automatic issue_store(input addr_t addr, input mem_func_e func, input word_t data);
        int waited;
        logic accepted;
        word_t w;
        waited    = 0;
        accepted  = 1'b0;
        store_req = '{valid: 1'b1, addr: addr, func: func, data: data};
        while (!accepted) begin
            #5;
            if (store_accept) begin
                accepted = 1'b1;
                w = shadow_word(addr >> 2);
                case (func)
                    MEM_BYTE: w[8 * addr[1:0] +: 8] = data[7:0];
                    MEM_HALF: w[16 * addr[1] +: 16] = data[15:0];
                    default:  w = data;
                endcase
                shadow[addr >> 2] = w;
            end else if (waited >= 60) begin
                report_failure("a store request was never accepted");
            end
            waited++;
            @(negedge clock);
        end
        store_req.valid = 1'b0;
    endtask

    task automatic wait_loads_done();
        int waited;
        waited = 0;
        while (pending_count() != 0) begin
            if (waited >= 100) begin
                report_failure("queued loads never received their fill results");
            end
            waited++;
            @(negedge clock);
        end
    endtask

    // fill results, read commands and writebacks
    always begin
        @(negedge clock);
        #5;
        cycle_count++;
        if (!reset) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (fill_results[i].valid) begin
                    if (!exp_pending[fill_results[i].lq_idx]) begin
                        report_failure("a fill result named a load that was not waiting");
                    end
                    check_value(test_name, exp_data[fill_results[i].lq_idx],
                                fill_results[i].data);
                    exp_pending[fill_results[i].lq_idx] = 1'b0;
                    fill_cycle[fill_results[i].lq_idx]  = cycle_count;
                end
            end
            if (mem_req.command == MEM_LOAD && mem_response_tag != '0
                    && mem_req.addr == watch_addr) begin
                read_count++;
            end
            if (mem_req.command == MEM_STORE) begin
                wb_count++;
                wb_addr = mem_req.addr;
                wb_data = mem_req.data;
            end
        end
    end

    hit_matches_request: assert property (@(posedge clock) disable iff (reset)
        load_hit_result.valid |-> load_req.valid && load_hit_result.lq_idx == load_req.lq_idx)
        else report_failure("a load hit result did not match the load request");

    read_block_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_req.command == MEM_LOAD |-> mem_req.addr[OFFSET_BITS-1:0] == '0)
        else report_failure("a read command carried an unaligned block address");

    initial begin
        logic   hit;
        int     waited;
        addr_t  rand_addr;
        addr_t  victim_addr;
        block_t victim_block;
        reset       = 1'b1;
        stall       = 1'b0;
        load_req    = '0;
        store_req   = '0;
        cycle_count = 0;
        read_count  = 0;
        wb_count    = 0;
        watch_addr  = '0;
        test_name   = "reset";
        for (int i = 0; i < 8; i++) begin
            exp_pending[i] = 1'b0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #5;
        check_value("reset", MEM_NONE, mem_req.command);
        check_value("reset", 0, {load_accept, store_accept, fill_results[0].valid,
                                 fill_results[1].valid});
        @(negedge clock);

        test_name = "load miss";
        // either word of the first block
        rand_addr = 32'h0000_1000 | (addr_t'($random(seed)) & 32'h0000_0004);
        issue_load(rand_addr, 3'd1, hit);
        check_value(test_name, 0, hit);
        wait_loads_done();

        // stall keeps the block pending while both loads queue
        test_name  = "merge";
        watch_addr = 32'h0000_2008;
        read_count = 0;
        stall      = 1'b1;
        issue_load(32'h0000_2008, 3'd2, hit);
        issue_load(32'h0000_200c, 3'd3, hit);
        stall = 1'b0;
        wait_loads_done();
        check_value(test_name, fill_cycle[2], fill_cycle[3]);
        check_value(test_name, 1, read_count);

        test_name = "store hits";
        issue_store(32'h0000_1001, MEM_BYTE, 32'h0000_00ab);
        issue_load(32'h0000_1000, 3'd4, hit);
        check_value(test_name, 1, hit);
        issue_store(32'h0000_1006, MEM_HALF, 32'h0000_beef);
        issue_load(32'h0000_1004, 3'd4, hit);
        check_value(test_name, 1, hit);
        issue_store(32'h0000_1004, MEM_WORD, 32'hcafe_f00d);
        issue_load(32'h0000_1004, 3'd4, hit);
        check_value(test_name, 1, hit);

        test_name = "store miss merge";
        stall     = 1'b1;
        issue_store(32'h0000_3014, MEM_WORD, 32'h1122_3344);
        issue_load(32'h0000_3014, 3'd4, hit);
        stall = 1'b0;
        wait_loads_done();

        // index 0 holds the dirty line written above
        test_name    = "dirty eviction";
        victim_addr  = 32'h0000_1000;
        victim_block = {shadow_word((victim_addr >> 2) + 1), shadow_word(victim_addr >> 2)};
        wb_count     = 0;
        issue_load(32'h0000_5000, 3'd5, hit);
        wait_loads_done();
        waited = 0;
        while (wb_count == 0) begin
            if (waited >= 20) begin
                report_failure("the dirty line was never written back");
            end
            waited++;
            @(negedge clock);
        end
        check_value(test_name, victim_addr, wb_addr);
        check_value(test_name, victim_block, wb_data);

        test_name = "back-pressure";
        stall     = 1'b1;
        issue_load(32'h0000_6018, 3'd5, hit);
        issue_load(32'h0000_6020, 3'd6, hit);
        issue_load(32'h0000_6028, 3'd7, hit);
        issue_load(32'h0000_6030, 3'd0, hit);
        load_req = '{valid: 1'b1, addr: 32'h0000_6038, lq_idx: 3'd1};
        repeat (6) begin
            #5;
            check_value(test_name, 0, load_accept);
            @(negedge clock);
        end
        stall = 1'b0;
        issue_load(32'h0000_6038, 3'd1, hit);
        check_value(test_name, 1, !(exp_pending[5] && exp_pending[6] && exp_pending[7]
                                    && exp_pending[0]));
        wait_loads_done();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== data_cache.f ====
src/dcache_pkg.sv
src/miss_queue.sv
src/miss_tracker.sv
src/cache_array.sv
src/memory_port.sv
src/data_cache.sv
testbench/memory_model.sv
testbench/data_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= data_cache_tb
FILELIST  ?= data_cache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
